//--- hw/packer_pkg.sv
// Shared bus field widths, command kinds and payload structs of the write-packet packer
package packer_pkg;

  // Request bus field widths
  localparam int ADDR_WIDTH   = 32;
  localparam int DATA_WIDTH   = 32;
  localparam int LENGTH_WIDTH = 4;

  // The length field holds beats minus one, so a burst is at most 16 beats long
  localparam int MAX_BURST = 2 ** LENGTH_WIDTH;

  // Bit of the command kind that marks a command followed by data beats
  localparam int WITH_DATA_BIT = 1;

  // WRITE is the only kind with WITH_DATA_BIT set
  typedef enum logic [1:0] {
    READ    = 2'b00,
    MESSAGE = 2'b01,
    WRITE   = 2'b10
  } command_kind_t;

  // Command channel payload, 38 bits
  typedef struct packed {
    command_kind_t           kind;
    logic [ADDR_WIDTH-1:0]   address;
    logic [LENGTH_WIDTH-1:0] length;
  } command_t;

  // Data channel payload, 33 bits
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic                  last;
  } data_beat_t;

endpackage

//--- hw/packer_fifo.sv
// Registered circular-buffer FIFO used by the packer for both command and write data payloads
`timescale 1ns/1ps

module packer_fifo #(
  parameter int  DEPTH   = 4,
  parameter type PAYLOAD = logic
)(
  input  logic   i_clk,
  input  logic   i_rst_n,
  input  logic   i_clear,
  input  logic   i_push_valid,
  input  PAYLOAD i_push_payload,
  output logic   o_push_accept,
  output logic   o_push,
  output logic   o_head_valid,
  output PAYLOAD o_head_payload,
  input  logic   i_pop,
  output logic   o_empty,
  output logic   o_full
);
  localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  localparam bit [PTR_WIDTH-1:0]   LAST_INDEX = PTR_WIDTH'(DEPTH - 1);
  localparam bit [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(DEPTH);

  PAYLOAD                 mem [DEPTH];
  logic [PTR_WIDTH-1:0]   write_ptr;
  logic [PTR_WIDTH-1:0]   read_ptr;
  logic [COUNT_WIDTH-1:0] count;
  logic                   empty;
  logic                   full;
  logic                   push;

  // Pointers wrap explicitly so that DEPTH need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
    if (ptr == LAST_INDEX) begin
      return '0;
    end
    return ptr + PTR_WIDTH'(1);
  endfunction

  always_comb begin
    empty = (count == '0);
    full  = (count == FULL_COUNT);
    push  = i_push_valid && (!full);
  end

  // Write side handshake, no bypass from the write side to the head
  assign o_push_accept = !full;
  assign o_push        = push;

  // Read side sees the stored head only
  assign o_head_valid   = !empty;
  assign o_head_payload = mem[read_ptr];

  assign o_empty = empty;
  assign o_full  = full;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      write_ptr <= '0;
    end
    else if (i_clear) begin
      write_ptr <= '0;
    end
    else if (push) begin
      write_ptr <= next_ptr(write_ptr);
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      read_ptr <= '0;
    end
    else if (i_clear) begin
      read_ptr <= '0;
    end
    else if (i_pop) begin
      read_ptr <= next_ptr(read_ptr);
    end
  end

  // Occupancy count, a push and a pop in the same cycle cancel out
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end
    else if (i_clear) begin
      count <= '0;
    end
    else begin
      case ({push, i_pop})
        2'b10:   count <= count + COUNT_WIDTH'(1);
        2'b01:   count <= count - COUNT_WIDTH'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[write_ptr] <= i_push_payload;
    end
  end

  // The reader may only pop an entry it has seen at the head
  a_no_pop_when_empty: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    i_pop |-> !empty
  ) else $error("FIFO popped while empty");

endmodule

//--- hw/packer_release.sv
// Release stage of the packer: holds write commands until their burst is stored, then sends
`timescale 1ns/1ps

module packer_release #(
  parameter int DATA_DEPTH = 16
)(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_clear,
  // Slave-side data FIFO write strobe and its last flag
  input  logic                   i_data_push,
  input  logic                   i_data_push_last,
  // Heads of the two FIFOs
  input  logic                   i_cmd_head_valid,
  input  packer_pkg::command_t   i_cmd_head,
  output logic                   o_cmd_pop,
  input  logic                   i_data_head_valid,
  input  packer_pkg::data_beat_t i_data_head,
  output logic                   o_data_pop,
  // Master-side channels
  output logic                   o_mcmd_valid,
  output packer_pkg::command_t   o_mcmd,
  input  logic                   i_scmd_accept,
  output logic                   o_mdata_valid,
  output packer_pkg::data_beat_t o_mdata,
  input  logic                   i_sdata_accept
);
  // Every stored burst has at least one beat, so the data FIFO depth bounds the count
  localparam int COUNT_WIDTH = $clog2(DATA_DEPTH + 1);

  localparam bit [COUNT_WIDTH-1:0] MAX_COUNT = COUNT_WIDTH'(DATA_DEPTH);

  logic [COUNT_WIDTH-1:0] packet_count;
  logic                   packet_count_up;
  logic                   packet_count_down;
  logic                   packet_ready;
  logic                   data_phase;
  logic                   head_with_data;
  logic                   cmd_ack;
  logic                   data_ack;

  // A burst becomes complete when its last beat enters the data FIFO
  assign packet_count_up = i_data_push && i_data_push_last;

  // Packet leaves when its last beat is taken by the downstream
  assign packet_count_down = data_ack && i_data_head.last;

  assign packet_ready   = (packet_count != '0);
  assign head_with_data = i_cmd_head.kind[packer_pkg::WITH_DATA_BIT];

  always_comb begin
    // No command passes while a write burst is going out
    if (data_phase) begin
      o_mcmd_valid = 1'b0;
    end
    else if (head_with_data) begin
      o_mcmd_valid = i_cmd_head_valid && packet_ready;
    end
    else begin
      o_mcmd_valid = i_cmd_head_valid;
    end
  end

  // Beats go out only behind their own write command
  assign o_mdata_valid = data_phase && i_data_head_valid;

  assign o_mcmd  = i_cmd_head;
  assign o_mdata = i_data_head;

  assign cmd_ack  = o_mcmd_valid && i_scmd_accept;
  assign data_ack = o_mdata_valid && i_sdata_accept;

  assign o_cmd_pop  = cmd_ack;
  assign o_data_pop = data_ack;

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      packet_count <= '0;
    end
    else if (i_clear) begin
      packet_count <= '0;
    end
    else if (packet_count_up && (!packet_count_down)) begin
      packet_count <= packet_count + COUNT_WIDTH'(1);
    end
    else if (packet_count_down && (!packet_count_up)) begin
      packet_count <= packet_count - COUNT_WIDTH'(1);
    end
  end

  // Set by a write command transfer, cleared by the transfer of its last beat
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      data_phase <= 1'b0;
    end
    else if (i_clear) begin
      data_phase <= 1'b0;
    end
    else if (cmd_ack && head_with_data) begin
      data_phase <= 1'b1;
    end
    else if (packet_count_down) begin
      data_phase <= 1'b0;
    end
  end

  // A last beat can only reach the master side after its burst was counted
  a_packet_count_underflow: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    packet_count_down |-> packet_ready
  ) else $error("write packet count underflow");

  // More complete bursts than data FIFO entries means the slave broke the burst rules
  a_packet_count_overflow: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (packet_count_up && !packet_count_down) |-> (packet_count != MAX_COUNT)
  ) else $error("write packet count overflow");

  // A burst that does not fit in the data FIFO would block the slave forever
  a_data_depth_holds_burst: assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    DATA_DEPTH >= packer_pkg::MAX_BURST
  ) else $error("DATA_DEPTH is smaller than the longest burst");

endmodule

//--- hw/packer_top.sv
// Top level of the write-packet packer: command FIFO, data FIFO and the release stage
`timescale 1ns/1ps

module packer_top #(
  parameter int COMMAND_DEPTH = 4,
  parameter int DATA_DEPTH    = 16
)(
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_clear,
  output logic [1:0]                        o_fifo_empty,
  output logic [1:0]                        o_fifo_full,
  // Slave side
  input  logic                              i_mcmd_valid,
  input  packer_pkg::command_kind_t         i_mcmd_kind,
  input  logic [packer_pkg::ADDR_WIDTH-1:0]   i_mcmd_addr,
  input  logic [packer_pkg::LENGTH_WIDTH-1:0] i_mcmd_length,
  output logic                              o_scmd_accept,
  input  logic                              i_mdata_valid,
  input  logic [packer_pkg::DATA_WIDTH-1:0]   i_mdata,
  input  logic                              i_mdata_last,
  output logic                              o_sdata_accept,
  // Master side
  output logic                              o_mcmd_valid,
  output packer_pkg::command_kind_t         o_mcmd_kind,
  output logic [packer_pkg::ADDR_WIDTH-1:0]   o_mcmd_addr,
  output logic [packer_pkg::LENGTH_WIDTH-1:0] o_mcmd_length,
  input  logic                              i_scmd_accept,
  output logic                              o_mdata_valid,
  output logic [packer_pkg::DATA_WIDTH-1:0]   o_mdata,
  output logic                              o_mdata_last,
  input  logic                              i_sdata_accept
);
  packer_pkg::command_t   slave_cmd;
  packer_pkg::data_beat_t slave_beat;
  logic                   cmd_head_valid;
  packer_pkg::command_t   cmd_head;
  logic                   cmd_pop;
  logic                   data_push;
  logic                   data_head_valid;
  packer_pkg::data_beat_t data_head;
  logic                   data_pop;
  packer_pkg::command_t   master_cmd;
  packer_pkg::data_beat_t master_beat;

  assign slave_cmd  = '{kind: i_mcmd_kind, address: i_mcmd_addr, length: i_mcmd_length};
  assign slave_beat = '{data: i_mdata, last: i_mdata_last};

  assign o_mcmd_kind   = master_cmd.kind;
  assign o_mcmd_addr   = master_cmd.address;
  assign o_mcmd_length = master_cmd.length;
  assign o_mdata       = master_beat.data;
  assign o_mdata_last  = master_beat.last;

  packer_fifo #(
    .DEPTH    (COMMAND_DEPTH          ),
    .PAYLOAD  (packer_pkg::command_t  )
  ) u_command_fifo (
    .i_clk          (i_clk            ),
    .i_rst_n        (i_rst_n          ),
    .i_clear        (i_clear          ),
    .i_push_valid   (i_mcmd_valid     ),
    .i_push_payload (slave_cmd        ),
    .o_push_accept  (o_scmd_accept    ),
    .o_push         (),
    .o_head_valid   (cmd_head_valid   ),
    .o_head_payload (cmd_head         ),
    .i_pop          (cmd_pop          ),
    .o_empty        (o_fifo_empty[0]  ),
    .o_full         (o_fifo_full[0]   )
  );

  packer_fifo #(
    .DEPTH    (DATA_DEPTH               ),
    .PAYLOAD  (packer_pkg::data_beat_t  )
  ) u_data_fifo (
    .i_clk          (i_clk            ),
    .i_rst_n        (i_rst_n          ),
    .i_clear        (i_clear          ),
    .i_push_valid   (i_mdata_valid    ),
    .i_push_payload (slave_beat       ),
    .o_push_accept  (o_sdata_accept   ),
    .o_push         (data_push        ),
    .o_head_valid   (data_head_valid  ),
    .o_head_payload (data_head        ),
    .i_pop          (data_pop         ),
    .o_empty        (o_fifo_empty[1]  ),
    .o_full         (o_fifo_full[1]   )
  );

  packer_release #(
    .DATA_DEPTH (DATA_DEPTH )
  ) u_release (
    .i_clk              (i_clk            ),
    .i_rst_n            (i_rst_n          ),
    .i_clear            (i_clear          ),
    .i_data_push        (data_push        ),
    .i_data_push_last   (i_mdata_last     ),
    .i_cmd_head_valid   (cmd_head_valid   ),
    .i_cmd_head         (cmd_head         ),
    .o_cmd_pop          (cmd_pop          ),
    .i_data_head_valid  (data_head_valid  ),
    .i_data_head        (data_head        ),
    .o_data_pop         (data_pop         ),
    .o_mcmd_valid       (o_mcmd_valid     ),
    .o_mcmd             (master_cmd       ),
    .i_scmd_accept      (i_scmd_accept    ),
    .o_mdata_valid      (o_mdata_valid    ),
    .o_mdata            (master_beat      ),
    .i_sdata_accept     (i_sdata_accept   )
  );

endmodule

//--- test/packer_tb_model.svh
// Reference model of the packer master stream, included inside the testbench module
`ifndef PACKER_TB_MODEL_SVH
`define PACKER_TB_MODEL_SVH

// One master transfer; bit 38 is set for a data beat and clear for a command
typedef logic [38:0] transfer_t;

// Master transfers still expected, in slave command order
transfer_t expected_queue[$];

function automatic transfer_t command_transfer(input packer_pkg::command_t cmd);
  return {1'b0, cmd};
endfunction

function automatic transfer_t beat_transfer(input logic [packer_pkg::DATA_WIDTH-1:0] data,
                                            input logic last);
  return {1'b1, 5'b00000, data, last};
endfunction

// Write data depends on the address and the beat index, so a lost or swapped beat shows up
function automatic logic [packer_pkg::DATA_WIDTH-1:0] beat_data(input logic [31:0] addr,
                                                               input int index);
  return addr ^ {index[7:0], ~index[7:0], index[7:0], 8'h5a};
endfunction

// A command goes out unchanged, and a write is followed by length+1 beats, last on the final one
function automatic void expect_command(input packer_pkg::command_t cmd);
  int beats;
  expected_queue.push_back(command_transfer(cmd));
  beats = (cmd.kind == packer_pkg::WRITE) ? int'(cmd.length) + 1 : 0;
  for (int i = 0; i < beats; i++) begin
    expected_queue.push_back(beat_transfer(beat_data(cmd.address, i), i == beats - 1));
  end
endfunction

function automatic void clear_model();
  expected_queue.delete();
endfunction

`endif

//--- test/packer_tb.sv
// Simulation top of the packer that drives both slave channels and checks the master stream
`timescale 1ns/1ps

module packer_tb;
  localparam int COMMAND_DEPTH   = 4;
  localparam int RESET_CYCLES    = 3;
  localparam int MAX_DELAY       = 3;
  localparam int RANDOM_COMMANDS = 40;
  // Every command of every test may carry a full burst behind random delays
  localparam int TOTAL_COMMANDS  = 8 + 2 + RANDOM_COMMANDS + COMMAND_DEPTH + 16 + 2 + 15;
  localparam int ALL_BEATS       = TOTAL_COMMANDS * packer_pkg::MAX_BURST;
  localparam int ITEM_CYCLES     = (packer_pkg::MAX_BURST + 1) * (MAX_DELAY + 1);
  localparam int WATCHDOG_CYCLES = (TOTAL_COMMANDS * ITEM_CYCLES + RESET_CYCLES) * 4 + 1000;

  logic i_clk, i_rst_n, i_clear;
  logic [1:0] o_fifo_empty, o_fifo_full;
  logic i_mcmd_valid, o_scmd_accept, i_mdata_valid, i_mdata_last, o_sdata_accept;
  logic o_mcmd_valid, i_scmd_accept, o_mdata_valid, o_mdata_last, i_sdata_accept;
  packer_pkg::command_kind_t i_mcmd_kind, o_mcmd_kind;
  logic [packer_pkg::ADDR_WIDTH-1:0] i_mcmd_addr, o_mcmd_addr;
  logic [packer_pkg::LENGTH_WIDTH-1:0] i_mcmd_length, o_mcmd_length;
  logic [packer_pkg::DATA_WIDTH-1:0] i_mdata, o_mdata;

  integer seed = 32'hf6e53131;
  string  test_name = "reset";
  int     compare_errors = 0;
  int     check_errors;
  int     errors_at_start;
  int     tests_passed;
  int     tests_failed;
  bit     master_stall;
  bit     master_random;
  bit     write_pending;
  logic [31:0] accept_bits;
  packer_pkg::command_t cmd_list[$];

  `include "packer_tb_model.svh"

  packer_top u_packer_top (.*);

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  // Downstream accepts are held low, random or always high
  initial begin
    i_scmd_accept  = 1'b1;
    i_sdata_accept = 1'b1;
    forever begin
      @(posedge i_clk);
      accept_bits = $random(seed);
      i_scmd_accept  <= !master_stall && (!master_random || accept_bits[0] || accept_bits[1]);
      i_sdata_accept <= !master_stall && (!master_random || accept_bits[2] || accept_bits[3]);
    end
  end

  task automatic compare_transfer(input transfer_t actual);
    transfer_t expected;
    assert (expected_queue.size() != 0) else begin
      $display("Unexpected master transfer %h in test %s", actual, test_name);
      compare_errors++;
    end
    if (expected_queue.size() != 0) begin
      expected = expected_queue.pop_front();
      assert (actual === expected) else begin
        $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
        compare_errors++;
      end
    end
  endtask

  // Outputs are stable at the falling edge and a transfer seen here completes at the next rising edge
  always @(negedge i_clk) begin
    if (i_rst_n) begin
      assert (!(write_pending && o_mcmd_valid)) else begin
        $display("Command offered in test %s before its write burst was stored", test_name);
        compare_errors++;
      end
      if (o_mcmd_valid && i_scmd_accept) begin
        compare_transfer({1'b0, o_mcmd_kind, o_mcmd_addr, o_mcmd_length});
      end
      if (o_mdata_valid && i_sdata_accept) begin
        compare_transfer(beat_transfer(o_mdata, o_mdata_last));
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Watchdog expired after %0d cycles in test %s", WATCHDOG_CYCLES, test_name);
    $display("Verification failed");
    $finish;
  end

  function automatic int random_delay(input int max_delay);
    return int'($unsigned($random(seed)) % (max_delay + 1));
  endfunction

  task automatic add_command(input packer_pkg::command_kind_t kind, input logic [31:0] addr,
                             input int length);
    packer_pkg::command_t cmd;
    cmd.kind    = kind;
    cmd.address = addr;
    cmd.length  = length[packer_pkg::LENGTH_WIDTH-1:0];
    cmd_list.push_back(cmd);
    expect_command(cmd);
  endtask

  task automatic add_random_commands(input int count, input bit allow_write);
    logic [31:0] word;
    packer_pkg::command_kind_t kind;
    cmd_list.delete();
    for (int n = 0; n < count; n++) begin
      word = $random(seed);
      case (allow_write ? int'(word % 3) : int'(word % 2))
        0:       kind = packer_pkg::READ;
        1:       kind = packer_pkg::MESSAGE;
        default: kind = packer_pkg::WRITE;
      endcase
      add_command(kind, $random(seed), int'(word[11:8]));
    end
  endtask

  // Both drivers start on a rising edge and return on the edge of their last transfer
  task automatic drive_commands(input int max_delay);
    int delay;
    foreach (cmd_list[n]) begin
      delay = random_delay(max_delay);
      if (delay > 0) begin
        i_mcmd_valid <= 1'b0;
        repeat (delay) @(posedge i_clk);
      end
      i_mcmd_valid  <= 1'b1;
      i_mcmd_kind   <= cmd_list[n].kind;
      i_mcmd_addr   <= cmd_list[n].address;
      i_mcmd_length <= cmd_list[n].length;
      do begin
        @(negedge i_clk);
      end while (!o_scmd_accept);
      @(posedge i_clk);
    end
    i_mcmd_valid <= 1'b0;
  endtask

  task automatic drive_data(input int max_delay, input int beat_limit);
    int delay;
    int beats;
    int sent;
    sent = 0;
    foreach (cmd_list[n]) begin
      beats = (cmd_list[n].kind == packer_pkg::WRITE) ? int'(cmd_list[n].length) + 1 : 0;
      for (int i = 0; i < beats && sent < beat_limit; i++) begin
        delay = random_delay(max_delay);
        if (delay > 0) begin
          i_mdata_valid <= 1'b0;
          repeat (delay) @(posedge i_clk);
        end
        i_mdata_valid <= 1'b1;
        i_mdata       <= beat_data(cmd_list[n].address, i);
        i_mdata_last  <= (i == beats - 1);
        do begin
          @(negedge i_clk);
        end while (!o_sdata_accept);
        @(posedge i_clk);
        sent++;
      end
    end
    i_mdata_valid <= 1'b0;
  endtask

  task automatic run_traffic(input int max_delay, input int beat_limit);
    fork
      drive_commands(max_delay);
      drive_data(max_delay, beat_limit);
    join
  endtask

  task automatic wait_drained();
    while (expected_queue.size() != 0) @(posedge i_clk);
    repeat (2) @(posedge i_clk);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = compare_errors + check_errors;
  endtask

  task automatic finish_test();
    wait_drained();
    if (compare_errors + check_errors == errors_at_start) begin
      tests_passed++;
      $display("Test %s finished without errors", test_name);
    end
    else begin
      tests_failed++;
      $display("Test %s finished with %0d errors", test_name,
               compare_errors + check_errors - errors_at_start);
    end
  endtask

  initial begin
    i_rst_n       = 1'b0;
    i_clear       = 1'b0;
    i_mcmd_valid  = 1'b0;
    i_mcmd_kind   = packer_pkg::READ;
    i_mcmd_addr   = '0;
    i_mcmd_length = '0;
    i_mdata_valid = 1'b0;
    i_mdata       = '0;
    i_mdata_last  = 1'b0;
    check_errors  = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    master_stall  = 1'b0;
    master_random = 1'b0;
    write_pending = 1'b0;
    repeat (RESET_CYCLES) @(posedge i_clk);
    i_rst_n <= 1'b1;
    @(posedge i_clk);

    start_test("reset_state");
    @(negedge i_clk);
    assert (o_fifo_empty == 2'b11 && o_fifo_full == 2'b00 && o_scmd_accept && o_sdata_accept
            && !o_mcmd_valid && !o_mdata_valid) else begin
      $display("Outputs not at their reset values after reset");
      check_errors++;
    end
    @(posedge i_clk);
    finish_test();

    start_test("read_message_order");
    add_random_commands(8, 1'b0);
    run_traffic(0, ALL_BEATS);
    finish_test();

    // The burst is held back, so neither the write nor the read behind it may leave
    start_test("write_waits_for_burst");
    cmd_list.delete();
    add_command(packer_pkg::WRITE, 32'h0000_1000, 3);
    add_command(packer_pkg::READ, 32'h0000_2000, 0);
    write_pending <= 1'b1;
    drive_commands(0);
    repeat (10) @(posedge i_clk);
    drive_data(0, ALL_BEATS);
    write_pending <= 1'b0;
    finish_test();

    start_test("random_mix");
    add_random_commands(RANDOM_COMMANDS, 1'b1);
    run_traffic(MAX_DELAY, ALL_BEATS);
    finish_test();

    start_test("backpressure_full");
    master_stall <= 1'b1;
    repeat (2) @(posedge i_clk);
    add_random_commands(COMMAND_DEPTH, 1'b0);
    drive_commands(0);
    @(negedge i_clk);
    assert (o_fifo_full == 2'b01 && !o_scmd_accept) else begin
      $display("Command FIFO not full after %0d commands with the master stalled", COMMAND_DEPTH);
      check_errors++;
    end
    @(posedge i_clk);
    master_stall  <= 1'b0;
    master_random <= 1'b1;
    add_random_commands(16, 1'b1);
    run_traffic(MAX_DELAY, ALL_BEATS);
    wait_drained();
    @(negedge i_clk);
    assert (o_fifo_empty == 2'b11 && o_fifo_full == 2'b00) else begin
      $display("FIFO flags wrong after draining in test %s", test_name);
      check_errors++;
    end
    @(posedge i_clk);
    master_random <= 1'b0;
    finish_test();

    // A stalled read is offered and part of a burst is stored when the clear arrives
    start_test("clear_partial");
    master_stall <= 1'b1;
    repeat (2) @(posedge i_clk);
    cmd_list.delete();
    add_command(packer_pkg::READ, 32'h0000_4000, 0);
    add_command(packer_pkg::WRITE, 32'h0000_3000, 7);
    run_traffic(0, 4);
    i_clear <= 1'b1;
    @(posedge i_clk);
    i_clear      <= 1'b0;
    master_stall <= 1'b0;
    clear_model();
    repeat (5) begin
      @(negedge i_clk);
      assert (o_fifo_empty == 2'b11 && !o_mcmd_valid && !o_mdata_valid) else begin
        $display("FIFOs not empty or a master valid seen after the clear");
        check_errors++;
      end
    end
    @(posedge i_clk);
    add_random_commands(15, 1'b1);
    run_traffic(MAX_DELAY, ALL_BEATS);
    finish_test();

    $display("Tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             compare_errors + check_errors);
    if (tests_failed == 0 && compare_errors + check_errors == 0) begin
      $display("Verification passed");
    end
    else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+test
hw/packer_pkg.sv
hw/packer_fifo.sv
hw/packer_release.sv
hw/packer_top.sv
test/packer_tb.sv

//--- Makefile
# Verilator build and run of the packer testbench

VERILATOR ?= verilator
TOP       ?= packer_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Verification passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
